// ==== source/csa_pkg.sv ====
package csa_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Widths and sizes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int word_width      = 32;
	localparam int operand_width   = 40;
	localparam int ops_per_group   = 4;
	localparam int words_per_group = 5;
	localparam int sum_width       = 42; // Four 40-bit operands need two extra bits.

	localparam int num_lanes  = 4;
	localparam int lane_idx_w = $clog2(num_lanes);

	localparam int group_depth = 4;
	localparam int lane_depth  = 2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Payload types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// op0 sits in the low bits, so a 160-bit chunk casts straight in.
	typedef struct packed {
		logic [operand_width-1:0] op3;
		logic [operand_width-1:0] op2;
		logic [operand_width-1:0] op1;
		logic [operand_width-1:0] op0;
	} operand_group_t;

	typedef struct packed {
		logic [sum_width-1:0] sum;
		logic [sum_width-1:0] carry; // Already shifted into place.
	} csa_pair_t;

endpackage

// ==== source/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
	parameter type payload_t = logic,
	parameter int depth = 2
)(
	input  logic axis_s_rclk,
	input  logic rst_n,
	input  logic wr_en,
	input  payload_t wr_data,
	input  logic rd_en,
	output payload_t rd_data,
	output logic full,
	output logic empty,
	output logic [$clog2(depth+1)-1:0] count
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	payload_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign full    = (count == cnt_w'(depth));
	assign empty   = (count == '0);
	assign do_wr   = wr_en && !full;
	assign do_rd   = rd_en && !empty;
	assign rd_data = mem[rd_ptr]; // Head shows without a read.

	always_ff @(posedge axis_s_rclk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== source/word_packer.sv ====
`timescale 1ns/1ps

module word_packer
	import csa_pkg::*;
(
	input  logic axis_s_rclk,
	input  logic rst_n,
	input  logic src_ready,
	input  logic [word_width-1:0] src_rdata,
	output logic src_ren,
	output operand_group_t group,
	output logic [num_lanes-1:0] lane_valid,
	input  logic [num_lanes-1:0] lane_ready
);

	localparam int chunk_width = words_per_group * word_width;

	typedef enum logic {
		st_issue,
		st_capture
	} fetch_state_t;

	fetch_state_t fetch_state;
	logic [2:0] word_idx;
	logic [chunk_width-1:0] chunk_buf;

	logic grp_wr;
	logic grp_rd;
	logic grp_full;
	logic grp_empty;
	operand_group_t grp_wdata;

	logic [lane_idx_w-1:0] rr_ptr;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fetch. One read request, then one capture cycle.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign src_ren = (fetch_state == st_issue) && src_ready && !grp_full;

	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			fetch_state <= st_issue;
			word_idx    <= '0;
			grp_wr      <= 1'b0;
		end else begin
			grp_wr <= 1'b0;
			case (fetch_state)
				st_issue: begin
					if (src_ren) begin
						fetch_state <= st_capture;
					end
				end
				st_capture: begin
					if (word_idx == 3'(words_per_group - 1)) begin
						word_idx <= '0;
						grp_wr   <= 1'b1; // Chunk complete.
					end else begin
						word_idx <= word_idx + 1'b1;
					end
					fetch_state <= st_issue;
				end
				default: fetch_state <= st_issue;
			endcase
		end
	end

	// First word lands in the lowest bits.
	always_ff @(posedge axis_s_rclk) begin
		if (fetch_state == st_capture) begin
			chunk_buf[int'(word_idx) * word_width +: word_width] <= src_rdata;
		end
	end

	assign grp_wdata = operand_group_t'(chunk_buf);

	stream_fifo #(
		.payload_t(operand_group_t),
		.depth(group_depth)
	) u_group_fifo (
		.axis_s_rclk(axis_s_rclk),
		.rst_n(rst_n),
		.wr_en(grp_wr),
		.wr_data(grp_wdata),
		.rd_en(grp_rd),
		.rd_data(group),
		.full(grp_full),
		.empty(grp_empty),
		.count()
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Round-robin dispatch.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign lane_valid = grp_empty ? '0 : (num_lanes'(1) << rr_ptr);
	assign grp_rd     = !grp_empty && lane_ready[rr_ptr];

	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			rr_ptr <= '0;
		end else if (grp_rd) begin
			rr_ptr <= (rr_ptr == lane_idx_w'(num_lanes - 1)) ? '0 : rr_ptr + 1'b1;
		end
	end

endmodule

// ==== source/csa_lane.sv ====
`timescale 1ns/1ps

module csa_lane
	import csa_pkg::*;
(
	input  logic axis_s_rclk,
	input  logic rst_n,
	input  logic in_valid,
	input  operand_group_t in_group,
	output logic in_ready,
	output logic pair_valid,
	output csa_pair_t pair,
	input  logic pair_ready
);

	logic [sum_width-1:0] a, b, c, d;
	logic [sum_width-1:0] s1, c1;
	logic [sum_width-1:0] s2, c2;

	logic stg_valid;
	csa_pair_t stg_pair;

	logic fifo_empty;
	logic [$clog2(lane_depth+1)-1:0] fifo_count;

	assign a = sum_width'(in_group.op0);
	assign b = sum_width'(in_group.op1);
	assign c = sum_width'(in_group.op2);
	assign d = sum_width'(in_group.op3);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// 4:2 reduction from two 3:2 stages.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign s1 = a ^ b ^ c;
	assign c1 = ((a & b) | (a & c) | (b & c)) << 1;
	assign s2 = s1 ^ c1 ^ d;
	assign c2 = ((s1 & c1) | (s1 & d) | (c1 & d)) << 1;

	// Room for the stage entry as well as the new group.
	assign in_ready = (int'(fifo_count) + int'(stg_valid)) < lane_depth;

	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			stg_valid <= 1'b0;
		end else begin
			stg_valid <= in_valid && in_ready;
		end
	end

	always_ff @(posedge axis_s_rclk) begin
		if (in_valid && in_ready) begin
			stg_pair.sum   <= s2;
			stg_pair.carry <= c2;
		end
	end

	stream_fifo #(
		.payload_t(csa_pair_t),
		.depth(lane_depth)
	) u_pair_fifo (
		.axis_s_rclk(axis_s_rclk),
		.rst_n(rst_n),
		.wr_en(stg_valid),
		.wr_data(stg_pair),
		.rd_en(pair_ready),
		.rd_data(pair),
		.full(),
		.empty(fifo_empty),
		.count(fifo_count)
	);

	assign pair_valid = !fifo_empty;

endmodule

// ==== source/sum_collector.sv ====
`timescale 1ns/1ps

module sum_collector
	import csa_pkg::*;
(
	input  logic axis_s_rclk,
	input  logic rst_n,
	input  logic [num_lanes-1:0] pair_valid,
	input  csa_pair_t pairs [num_lanes],
	output logic [num_lanes-1:0] pair_ready,
	output logic sum_valid,
	output logic [sum_width-1:0] sum_data,
	input  logic sum_ready
);

	logic [lane_idx_w-1:0] rr_ptr;
	logic can_load;
	logic take;
	csa_pair_t cur;

	assign can_load   = !sum_valid || sum_ready; // Empty or draining now.
	assign pair_ready = can_load ? (num_lanes'(1) << rr_ptr) : '0;
	assign take       = can_load && pair_valid[rr_ptr];
	assign cur        = pairs[rr_ptr];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output register and lane pointer.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			sum_valid <= 1'b0;
			rr_ptr    <= '0;
		end else begin
			if (take) begin
				sum_valid <= 1'b1;
				rr_ptr    <= (rr_ptr == lane_idx_w'(num_lanes - 1)) ? '0 : rr_ptr + 1'b1;
			end else if (sum_ready) begin
				sum_valid <= 1'b0;
			end
		end
	end

	// Final carry-propagate add.
	always_ff @(posedge axis_s_rclk) begin
		if (take) begin
			sum_data <= cur.sum + cur.carry;
		end
	end

endmodule

// ==== source/csa_top.sv ====
`timescale 1ns/1ps

module csa_top
	import csa_pkg::*;
(
	input  logic axis_s_rclk,
	input  logic rst_n,
	input  logic src_ready,
	input  logic [word_width-1:0] src_rdata,
	output logic src_ren,
	output logic sum_valid,
	output logic [sum_width-1:0] sum_data,
	input  logic sum_ready
);

	operand_group_t group;
	logic [num_lanes-1:0] lane_valid;
	logic [num_lanes-1:0] lane_ready;

	logic [num_lanes-1:0] pair_valid;
	logic [num_lanes-1:0] pair_ready;
	csa_pair_t pairs [num_lanes];

	word_packer u_packer (
		.axis_s_rclk(axis_s_rclk),
		.rst_n(rst_n),
		.src_ready(src_ready),
		.src_rdata(src_rdata),
		.src_ren(src_ren),
		.group(group),
		.lane_valid(lane_valid),
		.lane_ready(lane_ready)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lanes share the group bus.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar i = 0; i < num_lanes; i++) begin : g_lane
		csa_lane u_lane (
			.axis_s_rclk(axis_s_rclk),
			.rst_n(rst_n),
			.in_valid(lane_valid[i]),
			.in_group(group),
			.in_ready(lane_ready[i]),
			.pair_valid(pair_valid[i]),
			.pair(pairs[i]),
			.pair_ready(pair_ready[i])
		);
	end

	sum_collector u_collector (
		.axis_s_rclk(axis_s_rclk),
		.rst_n(rst_n),
		.pair_valid(pair_valid),
		.pairs(pairs),
		.pair_ready(pair_ready),
		.sum_valid(sum_valid),
		.sum_data(sum_data),
		.sum_ready(sum_ready)
	);

endmodule

// ==== sim/csa_top_asserts.sv ====
`timescale 1ns/1ps

module csa_top_asserts
	import csa_pkg::*;
(
	input logic axis_s_rclk,
	input logic rst_n,
	input logic src_ready,
	input logic src_ren,
	input logic sum_valid,
	input logic sum_ready,
	input logic [sum_width-1:0] sum_data
);

	logic ready_seen;
	bit violation = 1'b0; // Watched by the testbench.

	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			ready_seen <= 1'b0;
		end else if (src_ready) begin
			ready_seen <= 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Source side and output side rules.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_quiet_after_reset: assert property (@(posedge axis_s_rclk) disable iff (!rst_n)
		!ready_seen && !src_ready |-> !src_ren && !sum_valid)
		else begin
			violation = 1'b1;
			$error("src_ren or sum_valid high before the first src_ready");
		end

	a_ren_needs_ready: assert property (@(posedge axis_s_rclk) disable iff (!rst_n)
		src_ren |-> src_ready)
		else begin
			violation = 1'b1;
			$error("src_ren high while src_ready is low");
		end

	a_ren_single: assert property (@(posedge axis_s_rclk) disable iff (!rst_n)
		src_ren |=> !src_ren)
		else begin
			violation = 1'b1;
			$error("src_ren high on two cycles in a row");
		end

	a_sum_hold: assert property (@(posedge axis_s_rclk) disable iff (!rst_n)
		sum_valid && !sum_ready |=> sum_valid && $stable(sum_data))
		else begin
			violation = 1'b1;
			$error("sum_valid or sum_data changed while stalled");
		end

endmodule

bind csa_top csa_top_asserts u_asserts (
	.axis_s_rclk(axis_s_rclk),
	.rst_n(rst_n),
	.src_ready(src_ready),
	.src_ren(src_ren),
	.sum_valid(sum_valid),
	.sum_ready(sum_ready),
	.sum_data(sum_data)
);

// ==== sim/tb_csa_top.sv ====
`timescale 1ns/1ps

module tb_csa_top
	import csa_pkg::*;
();

	localparam int num_chunks   = 200;
	localparam int stall_chunk  = 100; // Back-pressure phase starts here.
	localparam int stall_idle   = 50;
	localparam int drain_cycles = 100;
	localparam int watchdog_ns  = (16 + 64 * num_chunks) * 10;

	logic axis_s_rclk;
	logic rst_n;
	logic src_ready;
	logic [word_width-1:0] src_rdata;
	logic src_ren;
	logic sum_valid;
	logic [sum_width-1:0] sum_data;
	logic sum_ready;

	logic [31:0] rng;
	logic [sum_width-1:0] exp_q [$];
	logic [words_per_group*word_width-1:0] chunk;
	int words_sent;
	int word_idx;
	int received;
	int idle_cycles;
	bit stalling;
	bit stall_done;
	bit ren_seen;

	csa_top u_dut (
		.axis_s_rclk(axis_s_rclk),
		.rst_n(rst_n),
		.src_ready(src_ready),
		.src_rdata(src_rdata),
		.src_ren(src_ren),
		.sum_valid(sum_valid),
		.sum_data(sum_data),
		.sum_ready(sum_ready)
	);

	initial begin
		axis_s_rclk = 1'b0;
		forever #5 axis_s_rclk = ~axis_s_rclk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Four 40-bit slices of the chunk, first word in the low bits.
	function automatic logic [sum_width-1:0] chunk_total(
		input logic [words_per_group*word_width-1:0] c
	);
		logic [sum_width-1:0] t;
		t = '0;
		for (int k = 0; k < ops_per_group; k++) begin
			t += sum_width'(c[k*operand_width +: operand_width]);
		end
		return t;
	endfunction

	task automatic check_total();
		logic [sum_width-1:0] expected;
		assert (exp_q.size() != 0) else begin
			$display("Output transfer at %0t while no total was expected", $time);
			$display("Done: errors found");
			$fatal(1, "unexpected output");
		end
		expected = exp_q.pop_front();
		assert (sum_data == expected) else begin
			$display("[FAIL] %0t sum_data: got %h, expected %h", $time, sum_data, expected);
			$display("Done: errors found");
			$fatal(1, "sum mismatch");
		end
		received++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Source model, sink and reference totals.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		rng = 32'h807d7c22;
		rst_n = 1'b0;
		src_ready = 1'b0;
		src_rdata = '0;
		sum_ready = 1'b0;
		chunk = '0;
		words_sent = 0;
		word_idx = 0;
		received = 0;
		idle_cycles = 0;
		stalling = 1'b0;
		stall_done = 1'b0;
		repeat (16) @(posedge axis_s_rclk);
		#1 rst_n = 1'b1;
		while (words_sent < num_chunks * words_per_group) begin
			@(posedge axis_s_rclk);
			ren_seen = src_ren;
			if (sum_valid && sum_ready) begin
				check_total();
			end
			#1;
			if (ren_seen) begin // Word goes out the cycle after the pulse.
				rng = lcg_next(rng);
				src_rdata = rng;
				chunk[word_idx*word_width +: word_width] = rng;
				words_sent++;
				if (word_idx == words_per_group - 1) begin
					exp_q.push_back(chunk_total(chunk));
					word_idx = 0;
				end else begin
					word_idx++;
				end
			end
			if (!stall_done && words_sent >= stall_chunk * words_per_group) begin
				stalling = 1'b1;
			end
			if (stalling) begin
				idle_cycles = ren_seen ? 0 : idle_cycles + 1;
				if (idle_cycles >= stall_idle) begin
					stalling = 1'b0;
					stall_done = 1'b1;
				end
			end
			rng = lcg_next(rng);
			src_ready = (words_sent < num_chunks * words_per_group) &&
				(stalling || rng[31:30] != 2'b00);
			sum_ready = !stalling && (rng[29:28] != 2'b00);
		end
		sum_ready = 1'b1;
		repeat (drain_cycles) begin // Totals still in flight.
			@(posedge axis_s_rclk);
			if (sum_valid) begin
				check_total();
			end
		end
		if (exp_q.size() == 0 && received == num_chunks) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("%0d totals still expected, %0d received", exp_q.size(), received);
			$display("Done: errors found");
			$fatal(1, "missing totals");
		end
	end

	always @(posedge axis_s_rclk) begin
		if (u_dut.u_asserts.violation) begin
			$display("A protocol assertion on csa_top failed");
			$display("Done: errors found");
			$fatal(1, "protocol violation");
		end
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired with %0d of %0d totals received", received, num_chunks);
		$display("Done: errors found");
		$fatal(1, "timeout");
	end

endmodule

// ==== sim.f ====
source/csa_pkg.sv
source/stream_fifo.sv
source/word_packer.sv
source/csa_lane.sv
source/sum_collector.sv
source/csa_top.sv
sim/csa_top_asserts.sv
sim/tb_csa_top.sv

// ==== Makefile ====
VERILATOR   ?= verilator
TOP         := tb_csa_top
FILELIST    := sim.f
LINT_FLAGS  := --lint-only -Wall --timing --assert
BUILD_FLAGS := --binary --timing --assert -j 0
RUN_ARGS    := +verilator+error+limit+100
OBJ_DIR     := obj_dir
LOG         := sim.log
PASS_TEXT   := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
